// File: basic_ptr_patch.sv
//////////////////////////////////////////////////
// Stage 3 of the loader
// Registers data writes and, after a program load,
// writes the end address into the BASIC pointers
// with one idle cycle between pointer writes
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module basic_ptr_patch import loader_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  mem_wr_t   gate_wr_i,
	input  logic      prg_end_i,
	input  mem_addr_t end_addr_i,
	output mem_wr_t   mem_wr_o
);

	patch_state_e state;
	logic [2:0]   ptr_idx;
	mem_addr_t    end_lat;
	mem_addr_t    ptr_src;
	mem_wr_t      ptr_wr;

	// First pointer goes out straight from the input address
	assign ptr_src = (state == PATCH_IDLE) ? end_addr_i : end_lat;

	always_comb begin
		ptr_wr.we   = 1'b1;
		ptr_wr.addr = BASIC_PTR_ADDR[ptr_idx];
		ptr_wr.data = ptr_idx[0] ? ptr_src[15:8] : ptr_src[7:0];
	end

	//////////////////////////////////////////////////
	// Pointer sequencer

	// Ptr_idx wraps back to zero after the eighth write
	always_ff @(posedge clk_sys) begin
		mem_wr_o.we <= 1'b0;
		case (state)
			PATCH_IDLE: begin
				if (prg_end_i) begin
					end_lat  <= end_addr_i;
					mem_wr_o <= ptr_wr;
					ptr_idx  <= ptr_idx + 3'd1;
					state    <= PATCH_GAP;
				end else begin
					mem_wr_o <= gate_wr_i;
				end
			end
			PATCH_GAP: begin
				state <= PATCH_WRITE;
			end
			PATCH_WRITE: begin
				mem_wr_o <= ptr_wr;
				ptr_idx  <= ptr_idx + 3'd1;
				if (ptr_idx == 3'd7) begin
					state <= PATCH_IDLE;
				end else begin
					state <= PATCH_GAP;
				end
			end
			default: state <= PATCH_IDLE;
		endcase
		if (reset) begin
			state       <= PATCH_IDLE;
			ptr_idx     <= 3'd0;
			mem_wr_o.we <= 1'b0;
		end
	end

	// A new download must wait until the pointers are written
	a_no_wr_during_patch: assert property (@(posedge clk_sys) disable iff (reset)
		gate_wr_i.we |-> (state == PATCH_IDLE))
		else $error("data write arrived during BASIC pointer patch");

endmodule

`default_nettype wire

// File: download_decode.sv
//////////////////////////////////////////////////
// Stage 1 of the loader
// Classifies the download by index, finds the start
// and end of the download level and tags each byte
// with a load operation for the region gate
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module download_decode import loader_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      dl_active_i,
	input  dl_index_t dl_index_i,
	input  mem_byte_t dl_ext_i,
	input  logic      dl_wr_i,
	input  dl_pos_t   dl_pos_i,
	input  mem_byte_t dl_data_i,
	output load_rec_t dec_rec_o
);

	// ROM image window within the file
	localparam dl_pos_t ROM_WIN_LO = 25'h0004000;
	localparam dl_pos_t ROM_WIN_HI = 25'h0008000;

	logic       active_d;
	logic       start_edge;
	logic       end_edge;
	file_kind_e kind;
	logic       seed_ok;
	mem_addr_t  seed_addr;
	logic       in_rom_win;
	load_rec_t  rec_nxt;

	//////////////////////////////////////////////////
	// Kind and edges

	always_comb begin
		case (dl_index_i)
			IDX_ROM:      kind = KIND_ROM;
			IDX_PRG:      kind = KIND_PRG;
			IDX_CART_HDR: kind = KIND_CART_HDR;
			IDX_CART_RAW: kind = KIND_CART_RAW;
			default:      kind = KIND_NONE;
		endcase
	end

	assign start_edge = dl_active_i & ~active_d;
	assign end_edge   = ~dl_active_i & active_d;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			active_d <= 1'b0;
		end else begin
			active_d <= dl_active_i;
		end
	end

	// Start address from the last extension character
	always_comb begin
		seed_ok   = 1'b0;
		seed_addr = '0;
		if (dl_ext_i >= "2" && dl_ext_i <= "9") begin
			seed_ok   = 1'b1;
			seed_addr = {dl_ext_i[3:0], 12'h000};
		end else if (dl_ext_i == "A" || dl_ext_i == "B") begin
			seed_ok   = 1'b1;
			seed_addr = {dl_ext_i[3:0] + 4'd9, 12'h000};
		end
	end

	assign in_rom_win = (dl_pos_i >= ROM_WIN_LO) && (dl_pos_i < ROM_WIN_HI);

	//////////////////////////////////////////////////
	// Record build

	// End edge first, then the seed, then the data strobe
	always_comb begin
		rec_nxt.kind = kind;
		rec_nxt.op   = OP_NONE;
		rec_nxt.data = dl_data_i;
		rec_nxt.addr = dl_pos_i[15:0] + ROM_OFFSET;
		if (end_edge && kind == KIND_PRG) begin
			rec_nxt.op = OP_END;
		end else if (start_edge && kind == KIND_CART_RAW && seed_ok) begin
			rec_nxt.op   = OP_SEED;
			rec_nxt.addr = seed_addr;
		end else if (dl_wr_i) begin
			case (kind)
				KIND_ROM: begin
					if (in_rom_win) begin
						rec_nxt.op = OP_ROM;
					end
				end
				KIND_PRG, KIND_CART_HDR: begin
					if (dl_pos_i == 25'd0) begin
						rec_nxt.op = OP_HDR_LO;
					end else if (dl_pos_i == 25'd1) begin
						rec_nxt.op = OP_HDR_HI;
					end else begin
						rec_nxt.op = OP_DATA;
					end
				end
				KIND_CART_RAW: rec_nxt.op = OP_DATA;
				default:       rec_nxt.op = OP_NONE;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		dec_rec_o <= rec_nxt;
		if (reset) begin
			dec_rec_o.op <= OP_NONE;
		end
	end

	// Host only strobes bytes inside a download
	a_wr_in_download: assert property (@(posedge clk_sys) disable iff (reset)
		dl_wr_i |-> dl_active_i)
		else $error("download strobe outside of an active download");

endmodule

`default_nettype wire

// File: loader_pkg.sv
//////////////////////////////////////////////////
// Shared types and constants for the download loader
// Import with a wildcard in each module header that
// needs the record types, enums or memory map values
//////////////////////////////////////////////////

`default_nettype none

package loader_pkg;

	//////////////////////////////////////////////////
	// Basic widths

	typedef logic [15:0] mem_addr_t;
	typedef logic [7:0]  mem_byte_t;
	typedef logic [24:0] dl_pos_t;
	typedef logic [7:0]  dl_index_t;

	// One bit per 8 KB cartridge block: 0000, 2000, 4000, 6000, A000
	typedef logic [4:0]  cart_blk_t;

	//////////////////////////////////////////////////
	// Enums

	typedef enum logic [2:0] {
		KIND_NONE,
		KIND_ROM,
		KIND_PRG,
		KIND_CART_HDR,
		KIND_CART_RAW
	} file_kind_e;

	typedef enum logic [2:0] {
		OP_NONE,
		OP_SEED,
		OP_HDR_LO,
		OP_HDR_HI,
		OP_DATA,
		OP_ROM,
		OP_END
	} load_op_e;

	typedef enum logic [1:0] {
		PATCH_IDLE,
		PATCH_WRITE,
		PATCH_GAP
	} patch_state_e;

	//////////////////////////////////////////////////
	// Records between stages

	// Addr holds the remapped ROM address or the seed address
	typedef struct packed {
		file_kind_e kind;
		load_op_e   op;
		mem_byte_t  data;
		mem_addr_t  addr;
	} load_rec_t;

	typedef struct packed {
		logic      we;
		mem_addr_t addr;
		mem_byte_t data;
	} mem_wr_t;

	//////////////////////////////////////////////////
	// Download index codes and memory map

	localparam dl_index_t IDX_ROM      = 8'd0;
	localparam dl_index_t IDX_PRG      = 8'd1;
	localparam dl_index_t IDX_CART_HDR = 8'd2;
	localparam dl_index_t IDX_CART_RAW = 8'd3;

	localparam mem_addr_t ROM_OFFSET   = 16'h8000;

	// BASIC pointers, entry 0 first; even entries get the low byte
	localparam mem_addr_t [7:0] BASIC_PTR_ADDR = {
		16'h00AF, 16'h00AE, 16'h0032, 16'h0031,
		16'h0030, 16'h002F, 16'h002E, 16'h002D
	};

endpackage

`default_nettype wire

// File: prg_loader.f
loader_pkg.sv
download_decode.sv
region_gate.sv
basic_ptr_patch.sv
prg_loader.sv
tb_prg_loader.sv

// File: prg_loader.sv
//////////////////////////////////////////////////
// Download loader top level
// Turns a host download stream into memory writes:
// decode, region gate, then BASIC pointer patch
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module prg_loader import loader_pkg::*; #(
	parameter mem_addr_t PRG_TOP  = 16'hA000,
	parameter mem_addr_t CART_TOP = 16'hC000
) (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      dl_active_i,
	input  dl_index_t dl_index_i,
	input  mem_byte_t dl_ext_i,
	input  logic      dl_wr_i,
	input  dl_pos_t   dl_pos_i,
	input  mem_byte_t dl_data_i,
	output mem_wr_t   mem_wr_o,
	output cart_blk_t cart_blk_o
);

	load_rec_t dec_rec;
	mem_wr_t   gate_wr;
	logic      prg_end;
	mem_addr_t end_addr;

	download_decode u_decode (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_ext_i    (dl_ext_i),
		.dl_wr_i     (dl_wr_i),
		.dl_pos_i    (dl_pos_i),
		.dl_data_i   (dl_data_i),
		.dec_rec_o   (dec_rec)
	);

	region_gate #(
		.PRG_TOP  (PRG_TOP),
		.CART_TOP (CART_TOP)
	) u_gate (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.dec_rec_i  (dec_rec),
		.gate_wr_o  (gate_wr),
		.prg_end_o  (prg_end),
		.end_addr_o (end_addr),
		.cart_blk_o (cart_blk_o)
	);

	basic_ptr_patch u_patch (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.gate_wr_i  (gate_wr),
		.prg_end_i  (prg_end),
		.end_addr_i (end_addr),
		.mem_wr_o   (mem_wr_o)
	);

endmodule

`default_nettype wire

// File: region_gate.sv
//////////////////////////////////////////////////
// Stage 2 of the loader
// Keeps the running load address, applies the
// program and cartridge limits, passes ROM writes
// and records which cartridge blocks were written
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module region_gate import loader_pkg::*; #(
	parameter mem_addr_t PRG_TOP  = 16'hA000,
	parameter mem_addr_t CART_TOP = 16'hC000
) (
	input  logic      clk_sys,
	input  logic      reset,
	input  load_rec_t dec_rec_i,
	output mem_wr_t   gate_wr_o,
	output logic      prg_end_o,
	output mem_addr_t end_addr_o,
	output cart_blk_t cart_blk_o
);

	mem_addr_t load_addr;
	mem_addr_t limit;
	logic      is_cart;
	logic      data_ok;

	// Block bit for an address, none for 8000-9FFF and above BFFF
	function automatic cart_blk_t blk_of(input mem_addr_t a);
		cart_blk_t b;
		b = '0;
		case (a[15:13])
			3'd0:    b[0] = 1'b1;
			3'd1:    b[1] = 1'b1;
			3'd2:    b[2] = 1'b1;
			3'd3:    b[3] = 1'b1;
			3'd5:    b[4] = 1'b1;
			default: b = '0;
		endcase
		return b;
	endfunction

	assign is_cart = (dec_rec_i.kind == KIND_CART_HDR) || (dec_rec_i.kind == KIND_CART_RAW);
	assign limit   = (dec_rec_i.kind == KIND_PRG) ? PRG_TOP : CART_TOP;
	assign data_ok = (dec_rec_i.op == OP_DATA) && (load_addr < limit);

	//////////////////////////////////////////////////
	// Load address

	always_ff @(posedge clk_sys) begin
		case (dec_rec_i.op)
			OP_SEED:   load_addr <= dec_rec_i.addr;
			OP_HDR_LO: load_addr[7:0] <= dec_rec_i.data;
			OP_HDR_HI: load_addr[15:8] <= dec_rec_i.data;
			OP_DATA: begin
				// Stops at the limit, so the end pointer saturates there
				if (data_ok) begin
					load_addr <= load_addr + 16'd1;
				end
			end
			default: ;
		endcase
	end

	//////////////////////////////////////////////////
	// Write out, end pulse and block mask

	always_ff @(posedge clk_sys) begin
		gate_wr_o.we <= 1'b0;
		prg_end_o    <= 1'b0;
		case (dec_rec_i.op)
			OP_DATA: begin
				gate_wr_o.addr <= load_addr;
				gate_wr_o.data <= dec_rec_i.data;
				if (data_ok) begin
					gate_wr_o.we <= 1'b1;
					if (is_cart) begin
						cart_blk_o <= cart_blk_o | blk_of(load_addr);
					end
				end
			end
			OP_ROM: begin
				gate_wr_o.we   <= 1'b1;
				gate_wr_o.addr <= dec_rec_i.addr;
				gate_wr_o.data <= dec_rec_i.data;
			end
			OP_END: begin
				prg_end_o  <= 1'b1;
				end_addr_o <= load_addr;
			end
			default: ;
		endcase
		if (reset) begin
			gate_wr_o.we <= 1'b0;
			prg_end_o    <= 1'b0;
			cart_blk_o   <= '0;
		end
	end

	// Block bits only ever get set until the next reset
	a_blk_sticky: assert property (@(posedge clk_sys) disable iff (reset)
		!$past(reset) |-> ((~cart_blk_o & $past(cart_blk_o)) == '0))
		else $error("cartridge block bit cleared outside reset");

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Compile and run the loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module tb_prg_loader \
	-f prg_loader.f \
	-o sim_prg_loader

./obj_dir/sim_prg_loader

// File: tb_prg_loader.sv
//////////////////////////////////////////////////
// Self-checking testbench for the download loader
// Runs program, ROM and cartridge downloads through
// the DUT and checks every memory write and the
// cartridge block mask against a reference model
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_prg_loader import loader_pkg::*; ();

	localparam mem_addr_t PRG_LIMIT  = 16'hA000;
	localparam mem_addr_t CART_LIMIT = 16'hC000;

	logic      clk_sys;
	logic      reset;
	logic      dl_active_i;
	dl_index_t dl_index_i;
	mem_byte_t dl_ext_i;
	logic      dl_wr_i;
	dl_pos_t   dl_pos_i;
	mem_byte_t dl_data_i;
	mem_wr_t   mem_wr_o;
	cart_blk_t cart_blk_o;

	logic [31:0] lfsr;
	mem_wr_t     exp_q[$];
	mem_wr_t     mon_exp;
	mem_addr_t   ref_addr;
	cart_blk_t   ref_blk;
	string       test_name;

	prg_loader #(
		.PRG_TOP  (PRG_LIMIT),
		.CART_TOP (CART_LIMIT)
	) dut0 (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl_active_i (dl_active_i),
		.dl_index_i  (dl_index_i),
		.dl_ext_i    (dl_ext_i),
		.dl_wr_i     (dl_wr_i),
		.dl_pos_i    (dl_pos_i),
		.dl_data_i   (dl_data_i),
		.mem_wr_o    (mem_wr_o),
		.cart_blk_o  (cart_blk_o)
	);

	always #4 clk_sys = ~clk_sys;

	//////////////////////////////////////////////////
	// Error reporting and compare tasks

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_wr(input string name, input mem_wr_t exp, input mem_wr_t act);
		if (act !== exp) begin
			stop_run($sformatf("Fail %s: expected addr %h data %h, actual addr %h data %h",
				name, exp.addr, exp.data, act.addr, act.data));
		end
	endtask

	task automatic check_blk(input string name, input cart_blk_t exp, input cart_blk_t act);
		if (act !== exp) begin
			stop_run($sformatf("Fail %s: expected cart_blk %b, actual cart_blk %b",
				name, exp, act));
		end
	endtask

	//////////////////////////////////////////////////
	// Random bytes and reference model

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic mem_byte_t rand_byte();
		mem_byte_t b;
		b = '0;
		for (int i = 0; i < 8; i++) begin
			lfsr = lfsr_next(lfsr);
			b    = {b[6:0], lfsr[0]};
		end
		return b;
	endfunction

	// 8000-9FFF and the top 16 KB have no cartridge block
	function automatic cart_blk_t blk_for(input mem_addr_t a);
		if (a < 16'h2000) return 5'b00001;
		if (a < 16'h4000) return 5'b00010;
		if (a < 16'h6000) return 5'b00100;
		if (a < 16'h8000) return 5'b01000;
		if (a >= 16'hA000 && a < 16'hC000) return 5'b10000;
		return 5'b00000;
	endfunction

	function automatic mem_addr_t ptr_addr(input int i);
		return (i < 6) ? mem_addr_t'(16'h002D + i) : mem_addr_t'(16'h00A8 + i);
	endfunction

	// Headerless start address from the extension character
	function automatic void ref_start(input dl_index_t idx, input mem_byte_t ext);
		if (idx == IDX_CART_RAW) begin
			if (ext >= "2" && ext <= "9") begin
				ref_addr = mem_addr_t'(ext - 8'h30) << 12;
			end else if (ext == "A" || ext == "B") begin
				ref_addr = 16'hA000 + (mem_addr_t'(ext - 8'h41) << 12);
			end
		end
	endfunction

	function automatic void ref_byte(input dl_index_t idx, input dl_pos_t pos,
		input mem_byte_t data);
		mem_wr_t   w;
		mem_addr_t top;
		logic      has_hdr;
		w.we    = 1'b1;
		w.addr  = ref_addr;
		w.data  = data;
		top     = (idx == IDX_PRG) ? PRG_LIMIT : CART_LIMIT;
		has_hdr = (idx == IDX_PRG) || (idx == IDX_CART_HDR);
		if (idx == IDX_ROM) begin
			if (pos >= 25'h4000 && pos < 25'h8000) begin
				w.addr = pos[15:0] + 16'h8000;
				exp_q.push_back(w);
			end
		end else if (has_hdr && pos == 25'd0) begin
			ref_addr[7:0] = data;
		end else if (has_hdr && pos == 25'd1) begin
			ref_addr[15:8] = data;
		end else if (idx >= IDX_PRG && idx <= IDX_CART_RAW && ref_addr < top) begin
			exp_q.push_back(w);
			if (idx != IDX_PRG) begin
				ref_blk = ref_blk | blk_for(ref_addr);
			end
			ref_addr = ref_addr + 16'd1;
		end
	endfunction

	// Next address into the eight BASIC pointers after a program
	function automatic void ref_end(input dl_index_t idx);
		mem_wr_t w;
		if (idx == IDX_PRG) begin
			for (int i = 0; i < 8; i++) begin
				w.we   = 1'b1;
				w.addr = ptr_addr(i);
				w.data = (i % 2 == 1) ? ref_addr[15:8] : ref_addr[7:0];
				exp_q.push_back(w);
			end
		end
	endfunction

	// Each DUT write must match the oldest expected write
	always @(negedge clk_sys) begin
		if (mem_wr_o.we) begin
			if (exp_q.size() == 0) begin
				stop_run($sformatf("unexpected memory write to %h during %s",
					mem_wr_o.addr, test_name));
			end else begin
				mon_exp = exp_q.pop_front();
				check_wr(test_name, mon_exp, mem_wr_o);
			end
		end
	end

	//////////////////////////////////////////////////
	// Stimulus tasks

	task automatic apply_reset();
		reset = 1'b1;
		repeat (4) @(negedge clk_sys);
		reset   = 1'b0;
		ref_blk = '0;
		@(negedge clk_sys);
		check_blk("reset", ref_blk, cart_blk_o);
	endtask

	task automatic begin_dl(input dl_index_t idx, input mem_byte_t ext);
		@(negedge clk_sys);
		dl_index_i  = idx;
		dl_ext_i    = ext;
		dl_active_i = 1'b1;
		ref_start(idx, ext);
	endtask

	task automatic send_byte(input dl_pos_t pos, input mem_byte_t data);
		@(negedge clk_sys);
		dl_wr_i   = 1'b1;
		dl_pos_i  = pos;
		dl_data_i = data;
		ref_byte(dl_index_i, pos, data);
	endtask

	task automatic send_header(input mem_addr_t addr);
		send_byte(25'd0, addr[7:0]);
		send_byte(25'd1, addr[15:8]);
	endtask

	task automatic send_range(input dl_pos_t first, input dl_pos_t last);
		for (dl_pos_t p = first; p <= last; p++) begin
			send_byte(p, rand_byte());
		end
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < 64) begin
			@(posedge clk_sys);
			cycles++;
		end
		if (exp_q.size() != 0) begin
			stop_run($sformatf("timed out in %s with %0d expected writes not seen",
				test_name, exp_q.size()));
		end
		@(negedge clk_sys);
	endtask

	// Ends the download, then keeps the bus quiet for the 16 cycle gap
	task automatic finish_dl();
		@(negedge clk_sys);
		dl_wr_i     = 1'b0;
		dl_active_i = 1'b0;
		ref_end(dl_index_i);
		wait_drain();
		check_blk(test_name, ref_blk, cart_blk_o);
		repeat (16) @(negedge clk_sys);
	endtask

	//////////////////////////////////////////////////
	// Test sequence

	initial begin
		clk_sys     = 1'b0;
		reset       = 1'b1;
		dl_active_i = 1'b0;
		dl_index_i  = '0;
		dl_ext_i    = '0;
		dl_wr_i     = 1'b0;
		dl_pos_i    = '0;
		dl_data_i   = '0;
		lfsr        = 32'hdf183419;
		ref_addr    = '0;
		ref_blk     = '0;
		test_name   = "reset";
		apply_reset();

		test_name = "program_load";
		begin_dl(IDX_PRG, 8'h00);
		send_header(16'h1001);
		send_range(25'd2, 25'd41);
		finish_dl();

		test_name = "program_limit";
		begin_dl(IDX_PRG, 8'h00);
		send_header(16'h9FF0);
		send_range(25'd2, 25'd33);
		finish_dl();

		// Both ranges straddle an edge of the ROM window
		test_name = "rom_image";
		begin_dl(IDX_ROM, 8'h00);
		send_range(25'h3FF0, 25'h4010);
		send_range(25'h7FF0, 25'h8010);
		finish_dl();

		test_name = "cart_header";
		begin_dl(IDX_CART_HDR, 8'h00);
		send_header(16'h6000);
		send_range(25'd2, 25'h2101);
		finish_dl();

		test_name = "cart_cross_top";
		begin_dl(IDX_CART_HDR, 8'h00);
		send_header(16'hBF00);
		send_range(25'd2, 25'h201);
		finish_dl();

		test_name = "cart_raw";
		apply_reset();
		begin_dl(IDX_CART_RAW, "A");
		send_range(25'd0, 25'd63);
		finish_dl();

		test_name = "unknown_index";
		apply_reset();
		begin_dl(8'd7, 8'h00);
		send_range(25'd0, 25'd31);
		finish_dl();

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire
